// ==== core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared definitions for the integer pipeline slice
// Sizes, credit widths, opcode and ALU enums, stage payload structs
//////////////////////////////////////////////////////////////////////

package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes

	localparam int XLEN         = 32;
	localparam int REG_ADDR_W   = 5;
	localparam int QUEUE_DEPTH  = 4;
	localparam int QPTR_W       = $clog2(QUEUE_DEPTH);
	// Must hold a full queue worth of credits on flush
	localparam int CREDIT_W     = $clog2(QUEUE_DEPTH + 1);
	localparam int OUT_CREDITS  = 2;
	localparam int OUT_CREDIT_W = $clog2(OUT_CREDITS + 1);

	//////////////////////////////////////////////////////////////////////
	// Encodings

	// Major opcodes handled by decode, anything else is illegal
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads

	// Upstream payload and queue entry
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     instruction;
	} fetch_t;

	// Decode to execute, operand_b already holds the immediate when used
	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		alu_op_e               alu_op;
		logic [XLEN-1:0]       operand_a;
		logic [XLEN-1:0]       operand_b;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_w;
		logic                  exception;
	} id_exs_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_w;
		logic                  exception;
		logic [XLEN-1:0]       result;
	} ex_wb_t;

	// Downstream retire record
	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_w;
		logic                  exception;
		logic [XLEN-1:0]       result;
	} retire_t;

endpackage

// ==== instr_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Input instruction FIFO with credit return
// Circular buffer, one credit per pop, full occupancy back on flush
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module instr_queue (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          flush,
	input  logic                          in_valid,
	input  core_pkg::fetch_t              in_data,
	input  logic                          pop,
	output core_pkg::fetch_t              head,
	output logic                          head_valid,
	output logic [core_pkg::CREDIT_W-1:0] in_credit
);
	import core_pkg::*;

	fetch_t              mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0]   wr_ptr;
	logic [QPTR_W-1:0]   rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic                do_pop;

	// Flush discards the head, so a pop in that cycle moves nothing
	assign do_pop     = pop && head_valid && !flush;
	assign head       = mem[rd_ptr];
	assign head_valid = (count != '0);

	// Count already includes any entry decode takes during the flush
	assign in_credit = flush ? count : CREDIT_W'(do_pop);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// Entry arriving with the flush is kept as the only one
			rd_ptr <= wr_ptr;
			wr_ptr <= wr_ptr + QPTR_W'(in_valid);
			count  <= CREDIT_W'(in_valid);
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CREDIT_W'(in_valid) - CREDIT_W'(do_pop);
		end
	end

	// Upstream only sends against a held credit
	a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (count < QUEUE_DEPTH) || do_pop || flush);

endmodule

// ==== reg_file.sv ====
//////////////////////////////////////////////////////////////////////
// Integer register file, 32 x XLEN
// Two read ports with write-through, one write port, x0 fixed at zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module reg_file (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
	input  logic                            we,
	input  logic [core_pkg::REG_ADDR_W-1:0] wa,
	input  logic [core_pkg::XLEN-1:0]       wd,
	output logic [core_pkg::XLEN-1:0]       rd1,
	output logic [core_pkg::XLEN-1:0]       rd2
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [32];

	// Architectural state starts at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Bypass the write so decode sees a value retiring this cycle
	assign rd1 = (rs1 == '0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

endmodule

// ==== decode_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Decode stage
// Opcode and funct decode, immediates, operand select, RAW stall
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module decode_stage (
	input  core_pkg::fetch_t                head,
	input  logic                            head_valid,
	input  logic                            pipe_stall,
	input  core_pkg::id_exs_t               id_exs_q,
	input  core_pkg::ex_wb_t                ex_wb_q,
	input  logic                            retiring,
	input  logic [core_pkg::XLEN-1:0]       rd1,
	input  logic [core_pkg::XLEN-1:0]       rd2,
	output logic [core_pkg::REG_ADDR_W-1:0] rs1,
	output logic [core_pkg::REG_ADDR_W-1:0] rs2,
	output logic                            pop,
	output core_pkg::id_exs_t               id_exs_d
);
	import core_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_u;
	logic                  legal;
	logic                  use_rs1;
	logic                  use_rs2;
	alu_op_e               alu_op;
	logic                  hazard;

	assign opcode  = head.instruction[6:0];
	assign rd_addr = head.instruction[11:7];
	assign funct3  = head.instruction[14:12];
	assign rs1     = head.instruction[19:15];
	assign rs2     = head.instruction[24:20];
	assign funct7  = head.instruction[31:25];
	assign imm_i   = {{20{head.instruction[31]}}, head.instruction[31:20]};
	assign imm_u   = {head.instruction[31:12], 12'b0};

	//////////////////////////////////////////////////////////////////////
	// Operation decode

	always_comb begin
		legal   = 1'b1;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		alu_op  = ALU_ADD;
		case (opcode)
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: alu_op = ALU_SLT;
					{7'b0000000, 3'b011}: alu_op = ALU_SLTU;
					{7'b0000000, 3'b100}: alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: alu_op = ALU_SRL;
					{7'b0100000, 3'b101}: alu_op = ALU_SRA;
					{7'b0000000, 3'b110}: alu_op = ALU_OR;
					{7'b0000000, 3'b111}: alu_op = ALU_AND;
					default:              legal  = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				case (funct3)
					3'b000: alu_op = ALU_ADD;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					3'b001: begin
						alu_op = ALU_SLL;
						legal  = (funct7 == 7'b0000000);
					end
					default: begin
						// Shift right, funct7 picks logical or arithmetic
						alu_op = (funct7[5]) ? ALU_SRA : ALU_SRL;
						legal  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
				endcase
			end
			OPC_LUI: alu_op = ALU_PASS_B;
			default: legal  = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// RAW hazard, no forwarding

	// A retiring ex_wb entry is visible through the register file bypass
	function automatic logic raw_hit(input logic [REG_ADDR_W-1:0] rs, input logic used);
		logic in_ex;
		logic in_wb;
		in_ex = id_exs_q.valid && id_exs_q.reg_w && (id_exs_q.rd == rs);
		in_wb = ex_wb_q.valid && ex_wb_q.reg_w && (ex_wb_q.rd == rs) && !retiring;
		return used && (rs != '0) && (in_ex || in_wb);
	endfunction

	assign hazard = raw_hit(rs1, use_rs1 && legal) || raw_hit(rs2, use_rs2 && legal);
	assign pop    = head_valid && !hazard && !pipe_stall;

	always_comb begin
		id_exs_d           = '0;
		id_exs_d.valid     = head_valid && !hazard;
		id_exs_d.pc        = head.pc;
		id_exs_d.alu_op    = alu_op;
		id_exs_d.rd        = rd_addr;
		id_exs_d.reg_w     = legal;
		id_exs_d.exception = !legal;
		if (legal) begin
			id_exs_d.operand_a = use_rs1 ? rd1 : '0;
			if (opcode == OPC_OP) begin
				id_exs_d.operand_b = rd2;
			end else if (opcode == OPC_LUI) begin
				id_exs_d.operand_b = imm_u;
			end else begin
				id_exs_d.operand_b = imm_i;
			end
		end
	end

endmodule

// ==== pipe_register.sv ====
//////////////////////////////////////////////////////////////////////
// Stage register for any packed payload
// Holds on stall, loads a zero bubble on reset or flush
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module pipe_register #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// All zeros means valid is clear, so the entry is a bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

// ==== execute_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage
// Integer ALU producing the writeback entry
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module execute_stage (
	input  core_pkg::id_exs_t entry,
	output core_pkg::ex_wb_t  result_entry
);
	import core_pkg::*;

	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] alu_out;

	assign a     = entry.operand_a;
	assign b     = entry.operand_b;
	assign shamt = b[4:0];

	always_comb begin
		case (entry.alu_op)
			ALU_ADD:    alu_out = a + b;
			ALU_SUB:    alu_out = a - b;
			ALU_AND:    alu_out = a & b;
			ALU_OR:     alu_out = a | b;
			ALU_XOR:    alu_out = a ^ b;
			ALU_SLT:    alu_out = XLEN'($signed(a) < $signed(b));
			ALU_SLTU:   alu_out = XLEN'(a < b);
			ALU_SLL:    alu_out = a << shamt;
			ALU_SRL:    alu_out = a >> shamt;
			ALU_SRA:    alu_out = $signed(a) >>> shamt;
			ALU_PASS_B: alu_out = b;
			default:    alu_out = '0;
		endcase
	end

	always_comb begin
		result_entry.valid     = entry.valid;
		result_entry.pc        = entry.pc;
		result_entry.rd        = entry.rd;
		result_entry.reg_w     = entry.reg_w;
		result_entry.exception = entry.exception;
		// Illegal instructions report zero
		result_entry.result    = entry.exception ? '0 : alu_out;
	end

endmodule

// ==== retire_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Retire stage
// Register write, retire record output, downstream credit counter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module retire_stage (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            flush,
	input  core_pkg::ex_wb_t                entry,
	input  logic                            retire_credit,
	output logic                            pipe_stall,
	output logic                            retiring,
	output logic                            we,
	output logic [core_pkg::REG_ADDR_W-1:0] wa,
	output logic [core_pkg::XLEN-1:0]       wd,
	output logic                            retire_valid,
	output core_pkg::retire_t               retire_data
);
	import core_pkg::*;

	logic [OUT_CREDIT_W-1:0] credits;
	logic                    has_credit;

	assign has_credit   = (credits != '0);
	assign pipe_stall   = entry.valid && !has_credit;
	// A flushed entry is killed here too
	assign retire_valid = entry.valid && has_credit && !flush;
	assign retiring     = retire_valid;

	assign we = retire_valid && entry.reg_w && (entry.rd != '0);
	assign wa = entry.rd;
	assign wd = entry.result;

	assign retire_data.pc        = entry.pc;
	assign retire_data.rd        = entry.rd;
	assign retire_data.reg_w     = entry.reg_w;
	assign retire_data.exception = entry.exception;
	assign retire_data.result    = entry.result;

	// Spend on each record, refill on each returned pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= OUT_CREDIT_W'(OUT_CREDITS);
		end else begin
			credits <= credits - OUT_CREDIT_W'(retire_valid) + OUT_CREDIT_W'(retire_credit);
		end
	end

	a_credit_range: assert property (@(posedge clk) disable iff (reset)
		credits <= OUT_CREDITS);

	// Downstream returns only what was spent
	a_credit_return: assert property (@(posedge clk) disable iff (reset)
		retire_credit |-> (credits < OUT_CREDITS) || retire_valid);

endmodule

// ==== int_pipeline_top.sv ====
//////////////////////////////////////////////////////////////////////
// Integer pipeline slice top level
// Queue, decode, ID/EX and EX/WB registers, execute, retire, regfile
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module int_pipeline_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          flush,
	input  logic                          in_valid,
	input  core_pkg::fetch_t              in_data,
	input  logic                          retire_credit,
	output logic [core_pkg::CREDIT_W-1:0] in_credit,
	output logic                          retire_valid,
	output core_pkg::retire_t             retire_data
);
	import core_pkg::*;

	fetch_t                head;
	logic                  head_valid;
	logic                  pop;
	logic                  pipe_stall;
	logic                  retiring;
	id_exs_t               id_exs_d;
	id_exs_t               id_exs_q;
	ex_wb_t                ex_wb_d;
	ex_wb_t                ex_wb_q;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0]       rd1;
	logic [XLEN-1:0]       rd2;
	logic                  we;
	logic [REG_ADDR_W-1:0] wa;
	logic [XLEN-1:0]       wd;

	instr_queue u_queue (
		.clk(clk), .reset(reset), .flush(flush),
		.in_valid(in_valid), .in_data(in_data), .pop(pop),
		.head(head), .head_valid(head_valid), .in_credit(in_credit)
	);

	decode_stage u_decode (
		.head(head), .head_valid(head_valid), .pipe_stall(pipe_stall),
		.id_exs_q(id_exs_q), .ex_wb_q(ex_wb_q), .retiring(retiring),
		.rd1(rd1), .rd2(rd2),
		.rs1(rs1), .rs2(rs2), .pop(pop), .id_exs_d(id_exs_d)
	);

	pipe_register #(.payload_t(id_exs_t)) u_id_exs (
		.clk(clk), .reset(reset), .stall(pipe_stall), .flush(flush),
		.d(id_exs_d), .q(id_exs_q)
	);

	execute_stage u_execute (
		.entry(id_exs_q), .result_entry(ex_wb_d)
	);

	pipe_register #(.payload_t(ex_wb_t)) u_ex_wb (
		.clk(clk), .reset(reset), .stall(pipe_stall), .flush(flush),
		.d(ex_wb_d), .q(ex_wb_q)
	);

	retire_stage u_retire (
		.clk(clk), .reset(reset), .flush(flush),
		.entry(ex_wb_q), .retire_credit(retire_credit),
		.pipe_stall(pipe_stall), .retiring(retiring),
		.we(we), .wa(wa), .wd(wd),
		.retire_valid(retire_valid), .retire_data(retire_data)
	);

	reg_file u_regs (
		.clk(clk), .reset(reset),
		.rs1(rs1), .rs2(rs2),
		.we(we), .wa(wa), .wd(wd),
		.rd1(rd1), .rd2(rd2)
	);

endmodule

// ==== tb_int_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the integer pipeline slice
// Credit-based sender, downstream credit model, reference register
// model, immediate assertions, cycle watchdog and summary report
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_int_pipeline;
	import core_pkg::*;

	localparam int MAX_CYCLES = 4000;

	logic                clk;
	logic                reset;
	logic                flush;
	logic                in_valid;
	fetch_t              in_data;
	logic                retire_credit;
	logic [CREDIT_W-1:0] in_credit;
	logic                retire_valid;
	retire_t             retire_data;

	logic [XLEN-1:0] model_regs [32];
	fetch_t          pending [$];
	logic [XLEN-1:0] next_pc;
	logic            send_en;
	logic            credit_en;
	int              sender_credits;
	int              spent;
	int              cycle;
	int              retired;
	int              illegal_retired;
	int              test_errors;
	int              total_errors;
	int              tests_run;
	int              tests_failed;

	int_pipeline_top uut (
		.clk(clk), .reset(reset), .flush(flush),
		.in_valid(in_valid), .in_data(in_data), .retire_credit(retire_credit),
		.in_credit(in_credit), .retire_valid(retire_valid), .retire_data(retire_data)
	);

	always #10 clk = ~clk;

	// Watchdog over the whole run
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reporting

	task automatic note_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		test_errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual) else begin
			$display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %s: passed", name);
		end else begin
			$display("Test %s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and reference model

	// Registers x0..x3 only, so dependences are frequent
	function automatic logic [31:0] random_instr();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		int          kind;
		rd   = 5'($urandom % 4);
		rs1  = 5'($urandom % 4);
		rs2  = 5'($urandom % 4);
		f3   = 3'($urandom);
		imm  = 12'($urandom);
		kind = $urandom % 10;
		f7   = 7'b0;
		if (kind < 4) begin
			if (($urandom % 2) == 1 && (f3 == 3'b000 || f3 == 3'b101)) begin
				f7 = 7'b0100000;
			end
			return {f7, rs2, rs1, f3, rd, 7'b0110011};
		end else if (kind < 8) begin
			if (f3 == 3'b001) begin
				imm[11:5] = 7'b0;
			end else if (f3 == 3'b101) begin
				imm[11:5] = (($urandom % 2) == 1) ? 7'b0100000 : 7'b0;
			end
			return {imm, rs1, f3, rd, 7'b0010011};
		end else if (kind == 8) begin
			return {20'($urandom), rd, 7'b0110111};
		end
		// Multiply group and load opcode are both unsupported
		if (($urandom % 2) == 1) begin
			return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
		end
		return {imm, rs1, f3, rd, 7'b0000011};
	endfunction

	// RV32I semantics on the model registers
	task automatic expected_record(input logic [31:0] ins, output logic legal,
			output logic [31:0] res);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [2:0]  f3;
		logic [6:0]  f7;
		a     = model_regs[ins[19:15]];
		b     = model_regs[ins[24:20]];
		imm   = {{20{ins[31]}}, ins[31:20]};
		f3    = ins[14:12];
		f7    = ins[31:25];
		legal = 1'b1;
		res   = '0;
		case (ins[6:0])
			7'b0110011: begin
				if (f7 == 7'b0100000 && f3 == 3'b000) begin
					res = a - b;
				end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
					res = $signed(a) >>> b[4:0];
				end else if (f7 != 7'b0) begin
					legal = 1'b0;
				end else begin
					case (f3)
						3'b000:  res = a + b;
						3'b001:  res = a << b[4:0];
						3'b010:  res = {31'b0, $signed(a) < $signed(b)};
						3'b011:  res = {31'b0, a < b};
						3'b100:  res = a ^ b;
						3'b101:  res = a >> b[4:0];
						3'b110:  res = a | b;
						default: res = a & b;
					endcase
				end
			end
			7'b0010011: begin
				case (f3)
					3'b000: res = a + imm;
					3'b010: res = {31'b0, $signed(a) < $signed(imm)};
					3'b011: res = {31'b0, a < imm};
					3'b100: res = a ^ imm;
					3'b110: res = a | imm;
					3'b111: res = a & imm;
					3'b001: begin
						legal = (f7 == 7'b0);
						res   = a << ins[24:20];
					end
					default: begin
						legal = (f7 == 7'b0) || (f7 == 7'b0100000);
						if (f7[5]) begin
							res = $signed(a) >>> ins[24:20];
						end else begin
							res = a >> ins[24:20];
						end
					end
				endcase
			end
			7'b0110111: res = {ins[31:12], 12'b0};
			default:    legal = 1'b0;
		endcase
		if (!legal) begin
			res = '0;
		end
	endtask

	// One clock cycle: drive after the falling edge, observe once settled
	task automatic step(input logic do_flush);
		fetch_t      exp_entry;
		logic        legal;
		logic [31:0] res;
		@(negedge clk);
		flush         = do_flush;
		in_valid      = 1'b0;
		retire_credit = 1'b0;
		if (send_en && !do_flush && sender_credits > 0 && ($urandom % 3) != 0) begin
			in_data.pc          = next_pc;
			in_data.instruction = random_instr();
			in_valid            = 1'b1;
			sender_credits--;
			pending.push_back(in_data);
			next_pc += 4;
		end
		if (credit_en && spent > 0 && ($urandom % 3) == 0) begin
			retire_credit = 1'b1;
		end
		#1;
		sender_credits += in_credit;
		assert (sender_credits <= QUEUE_DEPTH) else
			note_failure("sender holds more credits than the queue has entries");
		if (retire_valid) begin
			assert (spent < OUT_CREDITS) else
				note_failure("retire record sent without a downstream credit");
			assert (pending.size() != 0) else
				note_failure("retire record with no instruction in flight");
			spent++;
			retired++;
			if (pending.size() != 0) begin
				exp_entry = pending.pop_front();
				expected_record(exp_entry.instruction, legal, res);
				check_value("retire_data.pc", exp_entry.pc, retire_data.pc);
				check_value("retire_data.rd", 32'(exp_entry.instruction[11:7]), 32'(retire_data.rd));
				check_value("retire_data.reg_w", 32'(legal), 32'(retire_data.reg_w));
				check_value("retire_data.exception", 32'(!legal), 32'(retire_data.exception));
				check_value("retire_data.result", res, retire_data.result);
				if (legal && exp_entry.instruction[11:7] != 5'd0) begin
					model_regs[exp_entry.instruction[11:7]] = res;
				end
				if (!legal) begin
					illegal_retired++;
				end
			end
		end
		if (retire_credit) begin
			spent--;
		end
		// Everything in flight is killed
		if (do_flush) begin
			pending.delete();
		end
	endtask

	task automatic drain();
		send_en   = 1'b0;
		credit_en = 1'b1;
		while (pending.size() != 0 || spent != 0) begin
			step(1'b0);
		end
		repeat (4) begin
			step(1'b0);
		end
		check_value("sender_credits", QUEUE_DEPTH, sender_credits);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(50));
		clk             = 1'b0;
		reset           = 1'b1;
		flush           = 1'b0;
		in_valid        = 1'b0;
		in_data         = '0;
		retire_credit   = 1'b0;
		send_en         = 1'b0;
		credit_en       = 1'b1;
		sender_credits  = QUEUE_DEPTH;
		spent           = 0;
		next_pc         = 32'h0000_1000;
		cycle           = 0;
		retired         = 0;
		illegal_retired = 0;
		test_errors     = 0;
		total_errors    = 0;
		tests_run       = 0;
		tests_failed    = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		#1;
		assert (!retire_valid && in_credit == '0) else
			note_failure("outputs not idle after reset");

		// Random mix with randomly delayed downstream credits
		send_en = 1'b1;
		repeat (1000) begin
			step(1'b0);
		end
		drain();
		assert (illegal_retired > 0 && retired > illegal_retired) else
			note_failure("random mix did not retire both legal and illegal instructions");
		finish_test("arithmetic, hazards and illegal encodings");

		// Downstream withholds every credit
		retired   = 0;
		send_en   = 1'b1;
		credit_en = 1'b0;
		repeat (200) begin
			step(1'b0);
		end
		assert (retired <= OUT_CREDITS) else
			note_failure("more records retired than the downstream could hold");
		assert (pending.size() != 0) else
			note_failure("nothing was waiting behind the stalled retire stage");
		drain();
		finish_test("output back-pressure");

		send_en = 1'b1;
		repeat (300) begin
			step(1'b0);
		end
		while (pending.size() < 2) begin
			step(1'b0);
		end
		send_en = 1'b0;
		step(1'b1);
		retired = 0;
		repeat (60) begin
			step(1'b0);
		end
		assert (retired == 0) else
			note_failure("an instruction retired after the flush");
		check_value("sender_credits", QUEUE_DEPTH, sender_credits);
		// Later results show the killed instructions left no trace
		send_en = 1'b1;
		repeat (300) begin
			step(1'b0);
		end
		drain();
		finish_test("flush");

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
core_pkg.sv
instr_queue.sv
reg_file.sv
decode_stage.sv
pipe_register.sv
execute_stage.sv
retire_stage.sv
int_pipeline_top.sv
tb_int_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the integer pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_int_pipeline

out=$(./obj_dir/Vtb_int_pipeline)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -qx "Simulation finished: PASS"
